//--- source/zc_seq_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types, constants and helpers for the Zc sequencer.
// Imported by the decoder, step FSM, encoder and top level.
//////////////////////////////////////////////////////////////////////

package zc_seq_pkg;

  //////////////////////////////////////////////////////////////////////
  // Enumerations
  //////////////////////////////////////////////////////////////////////

  // Sequenced operation recognised by the decoder
  typedef enum logic [2:0] {
    OP_NONE,
    OP_PUSH,
    OP_POP,
    OP_POPRET,
    OP_POPRETZ,
    OP_MVSA01,
    OP_MVA01S
  } seq_op_e;

  // Step FSM states
  typedef enum logic [2:0] {
    S_IDLE,
    S_PUSH,
    S_POP,
    S_DMOVE,
    S_RA,
    S_SP,
    S_A0,
    S_RET
  } seq_state_e;

  // Step counter inside one sequence
  typedef logic [3:0] seq_cnt_t;

  // Decoded compressed instruction
  typedef struct packed {
    seq_op_e     op;
    // Number of s registers saved or restored
    logic [3:0]  regs_saved;
    // Stack base plus the extra 16-byte blocks from spimm
    logic [11:0] total_stack_adj;
    // Double move register selectors
    logic [2:0]  r1s;
    logic [2:0]  r2s;
  } seq_decode_t;

  //////////////////////////////////////////////////////////////////////
  // Encoding constants
  //////////////////////////////////////////////////////////////////////

  // Major opcodes of the emitted base instructions
  localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE = 7'b0100011;
  localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;
  localparam logic [6:0] OPCODE_JALR  = 7'b1100111;

  // ABI register numbers
  localparam logic [4:0] REG_RA = 5'd1;
  localparam logic [4:0] REG_SP = 5'd2;
  localparam logic [4:0] REG_A0 = 5'd10;
  localparam logic [4:0] REG_A1 = 5'd11;

  //////////////////////////////////////////////////////////////////////
  // Helper functions
  //////////////////////////////////////////////////////////////////////

  // Number of s registers covered by an rlist
  // rlist 4 is ra only, 15 covers s0..s11 since s10 alone is not encodable
  function automatic logic [3:0] regs_saved_of(input logic [3:0] rlist);
    logic [3:0] n;
    if (rlist < 4'd5) begin
      n = 4'd0;
    end else if (rlist == 4'd15) begin
      n = 4'd12;
    end else begin
      n = rlist - 4'd4;
    end
    return n;
  endfunction

  // Stack space for s registers plus ra, rounded up to 16 bytes
  function automatic logic [11:0] stack_base_of(input logic [3:0] rlist);
    logic [3:0]  n;
    logic [11:0] bytes;
    n     = regs_saved_of(rlist);
    // One word per s register and one for ra
    bytes = {6'd0, n + 4'd1, 2'b00};
    return (bytes + 12'd15) & 12'hff0;
  endfunction

  // s index to x register number
  function automatic logic [4:0] sreg_to_x(input logic [3:0] sidx);
    logic [4:0] x;
    if (sidx < 4'd2) begin
      // s0, s1 live at x8, x9
      x = 5'd8 + {1'b0, sidx};
    end else begin
      // s2..s11 live at x18..x27
      x = 5'd16 + {1'b0, sidx};
    end
    return x;
  endfunction

endpackage

//--- source/zc_decoder.sv
//////////////////////////////////////////////////////////////////////
// Decoder for sequenced Zc instructions.
// Recognises push/pop family and double moves in quadrant C2 and
// fills the decode struct; anything else decodes as OP_NONE.
//////////////////////////////////////////////////////////////////////

module zc_decoder #(
  parameter bit RV32E = 1'b0
) (
  input  logic [15:0]             instr_i,
  output zc_seq_pkg::seq_decode_t dec_o
);
  import zc_seq_pkg::*;

  logic [3:0] rlist;
  logic [2:0] r1s;
  logic [2:0] r2s;
  logic       rlist_legal;
  logic       move_legal;

  // Instruction fields
  assign rlist = instr_i[7:4];
  assign r1s   = instr_i[9:7];
  assign r2s   = instr_i[4:2];

  // rlist 0..3 reserved
  // RV32E has no s2..s11, so rlist stops at 6
  assign rlist_legal = RV32E ? ((rlist >= 4'd4) && (rlist <= 4'd6)) : (rlist >= 4'd4);

  // Both moves need distinct registers
  assign move_legal = (r1s != r2s) && (!RV32E || ((r1s < 3'd2) && (r2s < 3'd2)));

  // Stack sizes, only meaningful for push/pop family
  assign dec_o.regs_saved      = regs_saved_of(rlist);
  assign dec_o.total_stack_adj = stack_base_of(rlist) + {6'd0, instr_i[3:2], 4'd0};
  assign dec_o.r1s             = r1s;
  assign dec_o.r2s             = r2s;

  ////////////////////////////////////////////////////////////////////
  // Opcode match
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    dec_o.op = OP_NONE;
    // All sequenced instructions sit in C2 with funct3 101
    if ((instr_i[1:0] == 2'b10) && (instr_i[15:13] == 3'b101)) begin
      case (instr_i[12:10])
        3'b011: begin
          // Double moves
          if (move_legal) begin
            if (instr_i[6:5] == 2'b01) begin
              dec_o.op = OP_MVSA01;
            end else if (instr_i[6:5] == 2'b11) begin
              dec_o.op = OP_MVA01S;
            end
          end
        end
        3'b110: begin
          // cm.push / cm.pop
          if (rlist_legal) begin
            if (instr_i[9:8] == 2'b00) begin
              dec_o.op = OP_PUSH;
            end else if (instr_i[9:8] == 2'b10) begin
              dec_o.op = OP_POP;
            end
          end
        end
        3'b111: begin
          // cm.popretz / cm.popret
          if (rlist_legal) begin
            if (instr_i[9:8] == 2'b00) begin
              dec_o.op = OP_POPRETZ;
            end else if (instr_i[9:8] == 2'b10) begin
              dec_o.op = OP_POPRET;
            end
          end
        end
        default: begin
          dec_o.op = OP_NONE;
        end
      endcase
    end
  end

endmodule

//--- source/zc_step_fsm.sv
//////////////////////////////////////////////////////////////////////
// Step controller of the Zc sequencer.
// Walks one decoded instruction through its steps, one per output
// transfer, and drives valid/ready plus first/last markers.
//////////////////////////////////////////////////////////////////////

module zc_step_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  zc_seq_pkg::seq_decode_t dec_i,
  input  logic                    valid_i,
  input  logic                    ready_i,
  output zc_seq_pkg::seq_state_e  state_o,
  output zc_seq_pkg::seq_cnt_t    cnt_o,
  output logic                    valid_o,
  output logic                    ready_o,
  output logic                    seq_first_o,
  output logic                    seq_last_o
);
  import zc_seq_pkg::*;

  seq_state_e state_q;
  seq_state_e state_n;
  seq_cnt_t   cnt_q;
  logic       transfer;
  logic       last;

  // Output valid only for sequenced ops
  assign valid_o  = valid_i && (dec_i.op != OP_NONE);
  assign transfer = valid_o && ready_i;

  ////////////////////////////////////////////////////////////////////
  // Next state and last marker
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n = state_q;
    last    = 1'b0;
    case (state_q)
      S_IDLE: begin
        if ((dec_i.op == OP_MVSA01) || (dec_i.op == OP_MVA01S)) begin
          state_n = S_DMOVE;
        end else if (dec_i.regs_saved == 4'd0) begin
          // First step already stored/loaded ra
          state_n = S_SP;
        end else if (dec_i.regs_saved == 4'd1) begin
          state_n = S_RA;
        end else if (dec_i.op == OP_PUSH) begin
          state_n = S_PUSH;
        end else begin
          state_n = S_POP;
        end
      end
      S_PUSH, S_POP: begin
        // Move on after the last s register
        if (cnt_q == dec_i.regs_saved - 4'd1) begin
          state_n = S_RA;
        end
      end
      S_RA: state_n = S_SP;
      S_SP: begin
        if (dec_i.op == OP_POPRETZ) begin
          state_n = S_A0;
        end else if (dec_i.op == OP_POPRET) begin
          state_n = S_RET;
        end else begin
          state_n = S_IDLE;
          last    = 1'b1;
        end
      end
      S_A0: state_n = S_RET;
      S_DMOVE, S_RET: begin
        state_n = S_IDLE;
        last    = 1'b1;
      end
      default: state_n = S_IDLE;
    endcase
  end

  // Input consumed when nothing to emit or the final step goes out
  assign ready_o     = !valid_o || (ready_i && last);
  assign seq_first_o = (state_q == S_IDLE);
  assign seq_last_o  = last;
  assign state_o     = state_q;
  assign cnt_o       = cnt_q;

  ////////////////////////////////////////////////////////////////////
  // State and counter registers
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else if (!valid_o) begin
      // Nothing in flight
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else if (transfer) begin
      state_q <= state_n;
      cnt_q   <= last ? '0 : cnt_q + 4'd1;
    end
  end

  // A new sequence starts only when its first step is taken
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == S_IDLE && !transfer) |=> (state_q == S_IDLE));

  // s register steps stay inside the decoded register count
  assert property (@(posedge clk) disable iff (!rst_n)
    (valid_o && (state_q inside {S_PUSH, S_POP})) |-> (cnt_q < dec_i.regs_saved));

endmodule

//--- source/zc_instr_encoder.sv
//////////////////////////////////////////////////////////////////////
// Encoder for the emitted 32-bit base instructions.
// Pure combinational; the step comes from FSM state and counter,
// register and offset fields from the decode struct.
//////////////////////////////////////////////////////////////////////

module zc_instr_encoder (
  input  zc_seq_pkg::seq_decode_t dec_i,
  input  logic [15:0]             instr_i,
  input  zc_seq_pkg::seq_state_e  state_i,
  input  zc_seq_pkg::seq_cnt_t    cnt_i,
  output logic [31:0]             instr_o
);
  import zc_seq_pkg::*;

  logic        is_pop;
  logic        is_stack;
  logic [11:0] step_off;
  logic [11:0] mem_off;
  logic [3:0]  sidx;
  logic [4:0]  mem_reg;
  logic [4:0]  x_r1s;
  logic [4:0]  x_r2s;
  logic [11:0] sp_adj;

  // Op classes
  assign is_pop   = (dec_i.op == OP_POP) || (dec_i.op == OP_POPRET) ||
                    (dec_i.op == OP_POPRETZ);
  assign is_stack = is_pop || (dec_i.op == OP_PUSH);

  ////////////////////////////////////////////////////////////////////
  // Memory step fields
  ////////////////////////////////////////////////////////////////////

  // Byte distance of this step from the top of the frame, 4*(cnt+1)
  assign step_off = {6'd0, cnt_i + 4'd1, 2'b00};

  // Push counts down from sp, pop rewinds from sp+total
  assign mem_off = is_pop ? (dec_i.total_stack_adj - step_off) : (12'd0 - step_off);

  // Highest s register goes first
  assign sidx = dec_i.regs_saved - cnt_i - 4'd1;

  // ra once all s registers are done
  assign mem_reg = (cnt_i < dec_i.regs_saved) ? sreg_to_x(sidx) : REG_RA;

  // Stack pointer adjustment, grows down on push
  assign sp_adj = is_pop ? dec_i.total_stack_adj : (12'd0 - dec_i.total_stack_adj);

  // Double move registers
  assign x_r1s = sreg_to_x({1'b0, dec_i.r1s});
  assign x_r2s = sreg_to_x({1'b0, dec_i.r2s});

  ////////////////////////////////////////////////////////////////////
  // Instruction assembly
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    // Unsequenced words pass through zero extended
    instr_o = {16'd0, instr_i};
    case (state_i)
      S_IDLE, S_PUSH, S_POP, S_RA: begin
        if (is_stack) begin
          if (is_pop) begin
            // lw mem_reg, mem_off(sp)
            instr_o = {mem_off, REG_SP, 3'b010, mem_reg, OPCODE_LOAD};
          end else begin
            // sw mem_reg, mem_off(sp)
            instr_o = {mem_off[11:5], mem_reg, REG_SP, 3'b010, mem_off[4:0], OPCODE_STORE};
          end
        end else if (dec_i.op == OP_MVSA01) begin
          // addi s(r1s), a0, 0
          instr_o = {12'd0, REG_A0, 3'b000, x_r1s, OPCODE_OPIMM};
        end else if (dec_i.op == OP_MVA01S) begin
          // addi a0, s(r1s), 0
          instr_o = {12'd0, x_r1s, 3'b000, REG_A0, OPCODE_OPIMM};
        end
      end
      S_DMOVE: begin
        if (dec_i.op == OP_MVSA01) begin
          // addi s(r2s), a1, 0
          instr_o = {12'd0, REG_A1, 3'b000, x_r2s, OPCODE_OPIMM};
        end else begin
          // addi a1, s(r2s), 0
          instr_o = {12'd0, x_r2s, 3'b000, REG_A1, OPCODE_OPIMM};
        end
      end
      S_SP: begin
        // addi sp, sp, +/-total
        instr_o = {sp_adj, REG_SP, 3'b000, REG_SP, OPCODE_OPIMM};
      end
      S_A0: begin
        // Clear return value, addi a0, x0, 0
        instr_o = {12'd0, 5'd0, 3'b000, REG_A0, OPCODE_OPIMM};
      end
      S_RET: begin
        // jalr x0, 0(ra)
        instr_o = {12'd0, REG_RA, 3'b000, 5'd0, OPCODE_JALR};
      end
      default: begin
        instr_o = {16'd0, instr_i};
      end
    endcase
  end

  // Upstream holds the word for the whole sequence
  always_comb begin
    assert final ((state_i == S_IDLE) || (dec_i.op != OP_NONE));
  end

endmodule

//--- source/zc_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Top level of the Zc sequencer.
// Expands one compressed push/pop/move word into base instructions
// over a valid/ready handshake on both sides.
//////////////////////////////////////////////////////////////////////

module zc_sequencer #(
  parameter bit RV32E = 1'b0
) (
  input  logic        clk,
  input  logic        rst_n,
  // Upstream, compressed word in the low half
  input  logic [31:0] instr_i,
  input  logic        valid_i,
  output logic        ready_o,
  // Downstream, one base instruction per step
  output logic [31:0] instr_o,
  output logic        valid_o,
  input  logic        ready_i,
  output logic        seq_first_o,
  output logic        seq_last_o
);
  import zc_seq_pkg::*;

  seq_decode_t dec;
  seq_state_e  state;
  seq_cnt_t    cnt;

  // Decode compressed word
  zc_decoder #(
    .RV32E (RV32E)
  ) u_decoder (
    .instr_i (instr_i[15:0]),
    .dec_o   (dec)
  );

  // Step sequencing and handshake
  zc_step_fsm u_step_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .dec_i       (dec),
    .valid_i     (valid_i),
    .ready_i     (ready_i),
    .state_o     (state),
    .cnt_o       (cnt),
    .valid_o     (valid_o),
    .ready_o     (ready_o),
    .seq_first_o (seq_first_o),
    .seq_last_o  (seq_last_o)
  );

  // Build each emitted instruction
  zc_instr_encoder u_encoder (
    .dec_i   (dec),
    .instr_i (instr_i[15:0]),
    .state_i (state),
    .cnt_i   (cnt),
    .instr_o (instr_o)
  );

endmodule

//--- sim/tb_zc_model.svh
//////////////////////////////////////////////////////////////////////
// Reference model of the Zc sequencer, included by the testbench.
// Builds compressed words, the expected base instruction of each step
// and supplies the Galois LFSR used for random choices.
//////////////////////////////////////////////////////////////////////

`ifndef TB_ZC_MODEL_SVH
`define TB_ZC_MODEL_SVH

// Sequence kinds, POP..POPRETZ kept contiguous for loops
localparam int K_PUSH    = 1;
localparam int K_POP     = 2;
localparam int K_POPRET  = 3;
localparam int K_POPRETZ = 4;
localparam int K_MVSA01  = 5;
localparam int K_MVA01S  = 6;

// Galois LFSR state
logic [31:0] lfsr_state = 32'h7e8d_b3b5;

// n random bits, one LFSR step per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  logic        b;
  int          i;
  v = '0;
  for (i = 0; i < n; i++) begin
    b          = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    v = {v[30:0], b};
  end
  return v;
endfunction

// s0,s1 are x8,x9 and s2..s11 are x18..x27
function automatic logic [4:0] sx(input int idx);
  return (idx < 2) ? 5'(8 + idx) : 5'(16 + idx);
endfunction

// s registers covered by an rlist
function automatic int saved_count(input int rlist);
  int n;
  if (rlist == 4) begin
    n = 0;
  end else if (rlist == 15) begin
    n = 12;
  end else begin
    n = rlist - 4;
  end
  return n;
endfunction

// Frame size, base rounded to 16 bytes plus spimm blocks
function automatic int frame_total(input int rlist, input int spimm);
  int base;
  base = (saved_count(rlist) + 1) * 4;
  base = ((base + 15) / 16) * 16;
  return base + 16 * spimm;
endfunction

// Steps emitted for one word
function automatic int expected_len(input int kind, input int rlist);
  int n;
  case (kind)
    K_MVSA01, K_MVA01S: n = 2;
    K_POPRET:           n = saved_count(rlist) + 3;
    K_POPRETZ:          n = saved_count(rlist) + 4;
    default:            n = saved_count(rlist) + 2;
  endcase
  return n;
endfunction

// addi rd, rs1, imm
function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                          input int imm);
  logic [11:0] i;
  i = 12'(imm);
  return {i, rs1, 3'b000, rd, 7'b0010011};
endfunction

// lw or sw of register r at off(sp)
function automatic logic [31:0] mem_word(input bit load, input logic [4:0] r, input int off);
  logic [11:0] i;
  i = 12'(off);
  if (load) begin
    return {i, 5'd2, 3'b010, r, 7'b0000011};
  end
  return {i[11:5], r, 5'd2, 3'b010, i[4:0], 7'b0100011};
endfunction

// Compressed encoding, no legality check
function automatic logic [15:0] make_word(input int kind, input int rlist, input int spimm,
                                          input int r1s, input int r2s);
  logic [15:0] w;
  case (kind)
    K_PUSH:    w = {3'b101, 3'b110, 2'b00, 4'(rlist), 2'(spimm), 2'b10};
    K_POP:     w = {3'b101, 3'b110, 2'b10, 4'(rlist), 2'(spimm), 2'b10};
    K_POPRETZ: w = {3'b101, 3'b111, 2'b00, 4'(rlist), 2'(spimm), 2'b10};
    K_POPRET:  w = {3'b101, 3'b111, 2'b10, 4'(rlist), 2'(spimm), 2'b10};
    K_MVSA01:  w = {3'b101, 3'b011, 3'(r1s), 2'b01, 3'(r2s), 2'b10};
    default:   w = {3'b101, 3'b011, 3'(r1s), 2'b11, 3'(r2s), 2'b10};
  endcase
  return w;
endfunction

// Expected base instruction of one step
function automatic logic [31:0] expected_word(input int kind, input int rlist, input int spimm,
                                              input int r1s, input int r2s, input int step);
  int rs;
  int total;
  int off;
  bit load;
  rs    = saved_count(rlist);
  total = frame_total(rlist, spimm);
  load  = (kind != K_PUSH);
  if (kind == K_MVSA01) begin
    return (step == 0) ? addi_word(sx(r1s), 5'd10, 0) : addi_word(sx(r2s), 5'd11, 0);
  end
  if (kind == K_MVA01S) begin
    return (step == 0) ? addi_word(5'd10, sx(r1s), 0) : addi_word(5'd11, sx(r2s), 0);
  end
  // Push counts down from sp, pop from sp+total
  off = load ? total - 4 * (step + 1) : -4 * (step + 1);
  if (step < rs) begin
    return mem_word(load, sx(rs - 1 - step), off);
  end
  if (step == rs) begin
    return mem_word(load, 5'd1, off);
  end
  if (step == rs + 1) begin
    return addi_word(5'd2, 5'd2, load ? total : -total);
  end
  if ((kind == K_POPRETZ) && (step == rs + 2)) begin
    return addi_word(5'd10, 5'd0, 0);
  end
  // jalr x0, 0(ra)
  return {12'd0, 5'd1, 3'b000, 5'd0, 7'b1100111};
endfunction

`endif

//--- sim/tb_zc_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the Zc sequencer.
// Directed tests feed compressed words and compare each emitted step,
// the first/last markers and the handshake against the model.
//////////////////////////////////////////////////////////////////////

module tb_zc_sequencer;

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 16;
  // Watchdog bound: word count, 16 steps with up to 3 stall cycles each
  localparam int MAX_SEQUENCES  = 160;
  localparam int MAX_SEQ_CYCLES = 16 * 4 + 4;
  localparam int WATCHDOG_TIME  =
    (RESET_CYCLES + MAX_SEQUENCES * MAX_SEQ_CYCLES) * CLK_PERIOD * 2;

  logic        clk;
  logic        rst_n;
  logic [31:0] instr_i;
  logic        valid_i;
  logic        ready_o;
  logic [31:0] instr_o;
  logic        valid_o;
  logic        ready_i;
  logic        seq_first_o;
  logic        seq_last_o;

  int          errors;
  int          checks;
  int          tests;
  // Word and step under test, for error lines
  logic [15:0] cur_word;
  int          cur_step;

  `include "tb_zc_model.svh"

  zc_sequencer #(
    .RV32E (1'b0)
  ) UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_i     (instr_i),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .instr_o     (instr_o),
    .valid_o     (valid_o),
    .ready_i     (ready_i),
    .seq_first_o (seq_first_o),
    .seq_last_o  (seq_last_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("error: %s got %h expected %h (word %h, step %0d)",
               name, got, exp, cur_word, cur_step);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      $display("error: %s got %h expected %h (word %h, step %0d)",
               name, got, exp, cur_word, cur_step);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int n, input int start);
    tests++;
    $display("%s: %0d words, %0d errors", name, n, errors - start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  // One sequenced word, optional random stalls before each step
  task automatic run_sequence(input int kind, input int rlist, input int spimm,
                              input int r1s, input int r2s, input bit stall);
    int          len;
    int          hold;
    bit          done;
    bit          holding;
    logic [31:0] held;
    cur_word = make_word(kind, rlist, spimm, r1s, r2s);
    len      = expected_len(kind, rlist);
    cur_step = 0;
    done     = 1'b0;
    holding  = 1'b0;
    held     = '0;
    hold     = stall ? int'(rand_bits(2)) : 0;
    @(posedge clk);
    instr_i <= {16'd0, cur_word};
    valid_i <= 1'b1;
    ready_i <= (hold == 0);
    while (!done) begin
      // Outputs settle by mid cycle
      @(negedge clk);
      check_bit("valid_o", valid_o, 1'b1);
      if (valid_o !== 1'b1) begin
        break;
      end
      check_bit("seq_first_o", seq_first_o, cur_step == 0);
      check_bit("seq_last_o", seq_last_o, cur_step == len - 1);
      // Word consumed only as the final step goes out
      check_bit("ready_o", ready_o, ready_i && (cur_step == len - 1));
      if (holding) begin
        check_word("instr_o", instr_o, held);
      end
      if (ready_i) begin
        check_word("instr_o", instr_o,
                   expected_word(kind, rlist, spimm, r1s, r2s, cur_step));
        cur_step++;
        holding = 1'b0;
        hold    = stall ? int'(rand_bits(2)) : 0;
        done    = (cur_step == len);
      end else begin
        held    = instr_o;
        holding = 1'b1;
        hold--;
      end
      if (!done) begin
        @(posedge clk);
        ready_i <= (hold == 0);
      end
    end
    @(posedge clk);
    valid_i <= 1'b0;
    ready_i <= 1'b0;
  endtask

  // Word that must not be sequenced
  task automatic expect_dropped(input logic [15:0] word);
    cur_word = word;
    cur_step = 0;
    @(posedge clk);
    instr_i <= {16'd0, word};
    valid_i <= 1'b1;
    ready_i <= (rand_bits(1) != 0);
    @(negedge clk);
    check_bit("valid_o", valid_o, 1'b0);
    check_bit("ready_o", ready_o, 1'b1);
    @(posedge clk);
    valid_i <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_push_all();
    int start;
    int rl;
    int sp;
    start = errors;
    for (rl = 4; rl <= 15; rl++) begin
      for (sp = 0; sp < 4; sp++) begin
        run_sequence(K_PUSH, rl, sp, 0, 0, 1'b0);
      end
    end
    report_test("push, every rlist and spimm", 48, start);
  endtask

  task automatic test_pop_family();
    int start;
    int k;
    int i;
    start = errors;
    for (k = K_POP; k <= K_POPRETZ; k++) begin
      for (i = 0; i < 12; i++) begin
        run_sequence(k, 4 + int'(rand_bits(4)) % 12, int'(rand_bits(2)), 0, 0, 1'b0);
      end
    end
    report_test("pop, popret, popretz", 36, start);
  endtask

  task automatic test_double_moves();
    int start;
    int k;
    int i;
    int r1;
    int r2;
    start = errors;
    for (k = K_MVSA01; k <= K_MVA01S; k++) begin
      for (i = 0; i < 12; i++) begin
        r1 = int'(rand_bits(3));
        // Offset of 1..7 keeps r2 distinct
        r2 = (r1 + 1 + int'(rand_bits(3)) % 7) % 8;
        run_sequence(k, 0, 0, r1, r2, 1'b0);
      end
    end
    report_test("mvsa01, mva01s", 24, start);
  endtask

  task automatic test_illegal();
    int start;
    int rl;
    int k;
    int r;
    start = errors;
    // Reserved rlist 0..3
    for (rl = 0; rl < 4; rl++) begin
      for (k = K_PUSH; k <= K_POPRETZ; k++) begin
        expect_dropped(make_word(k, rl, rl, 0, 0));
      end
    end
    // Same register on both sides of a move
    for (r = 0; r < 8; r++) begin
      expect_dropped(make_word(K_MVSA01 + r % 2, 0, 0, r, r));
    end
    // Move group with reserved bits 6:5
    expect_dropped(16'hac8a);
    // c.nop, c.addi, c.lw, c.mv, c.jr, c.fsdsp-like
    expect_dropped(16'h0001);
    expect_dropped(16'h0505);
    expect_dropped(16'h4398);
    expect_dropped(16'h852e);
    expect_dropped(16'h8082);
    expect_dropped(16'hb006);
    report_test("illegal and plain words", 31, start);
  endtask

  task automatic test_backpressure();
    int start;
    int i;
    int k;
    int r1;
    start = errors;
    for (i = 0; i < 12; i++) begin
      k  = 1 + int'(rand_bits(3)) % 6;
      r1 = int'(rand_bits(3));
      run_sequence(k, 4 + int'(rand_bits(4)) % 12, int'(rand_bits(2)),
                   r1, (r1 + 1 + int'(rand_bits(3)) % 7) % 8, 1'b1);
    end
    report_test("back-pressure", 12, start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main flow and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk     = 1'b0;
    rst_n   <= 1'b0;
    instr_i <= '0;
    valid_i <= 1'b0;
    ready_i <= 1'b0;
    errors  = 0;
    checks  = 0;
    tests   = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    test_push_all();
    test_pop_family();
    test_double_moves();
    test_illegal();
    test_backpressure();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired before the tests finished");
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- zc_sequencer.f
+incdir+sim
source/zc_seq_pkg.sv
source/zc_decoder.sv
source/zc_step_fsm.sv
source/zc_instr_encoder.sv
source/zc_sequencer.sv
sim/tb_zc_sequencer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the Zc sequencer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_zc_sequencer \
  -f zc_sequencer.f \
  --Mdir "$BUILD_DIR" -o Vtb_zc_sequencer
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_zc_sequencer" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
exit 0
